// ==== logic/ts_filter_settings.svh ====
`ifndef TS_FILTER_SETTINGS_SVH
`define TS_FILTER_SETTINGS_SVH

// register port
`define TS_DATA_W 32
`define TS_ADDR_W 8

// filter slots with the monitors first
`define TS_MON_NUM 2
`define TS_REP_NUM 2
`define TS_SLOT_NUM 4
`define TS_SLOT_W 2

// packet geometry
`define TS_PKT_BYTES 188
`define TS_PKT_WORDS 47
`define TS_PID_W 13
`define TS_IDX_W 6

// capture and replacement window and the value for holes in the map
`define TS_DATA_BASE 128
`define TS_UNMAPPED 32'hFF00FF00

`endif

// ==== logic/ts_filter_pkg.sv ====
`include "ts_filter_settings.svh"
`default_nettype none

package ts_filter_pkg;

	// registers below the data window
	typedef enum logic [`TS_ADDR_W-1:0] {
		ADDR_INDEX      = 0,
		ADDR_PID        = 1,
		ADDR_RUN_ENABLE = 2,
		ADDR_CMD        = 3,
		ADDR_STATUS     = 4
	} reg_addr_e;

	// values written to ADDR_CMD
	typedef enum logic [`TS_DATA_W-1:0] {
		CMD_NONE               = 0,
		CMD_WRITE_REPLACE_DATA = 1,
		CMD_READ_REQUEST       = 2
	} cmd_e;

	// packet position as seen by a bank parser
	typedef enum logic [1:0] {
		PKT_IDLE,
		PKT_HEADER,
		PKT_BODY
	} pkt_state_e;

endpackage

`default_nettype wire

// ==== logic/filter_ctrl_if.sv ====
`timescale 1ns/100ps
`include "ts_filter_settings.svh"
`default_nettype none

interface filter_ctrl_if;

	// slot table with the first monitor at index 0
	logic [`TS_SLOT_NUM-1:0][`TS_PID_W-1:0] pid_table;
	logic [`TS_SLOT_NUM-1:0]                run_enable;
	// one cycle per read request
	logic [`TS_SLOT_NUM-1:0]                read_req;
	// replacement word write
	logic                                   rep_wr;
	logic [`TS_SLOT_W-1:0]                  rep_slot;
	logic [`TS_IDX_W-1:0]                   rep_index;
	logic [`TS_DATA_W-1:0]                  rep_data;

	modport regs (
		output pid_table, run_enable, read_req,
		output rep_wr, rep_slot, rep_index, rep_data
	);

	modport bank (
		input pid_table, run_enable, read_req,
		input rep_wr, rep_slot, rep_index, rep_data
	);

endinterface

`default_nettype wire

// ==== logic/capture_if.sv ====
`timescale 1ns/100ps
`include "ts_filter_settings.svh"
`default_nettype none

interface capture_if;

	logic                  cap_wr;
	logic [`TS_IDX_W-1:0]  cap_index;
	logic [`TS_DATA_W-1:0] cap_data;
	// high with the write of word 46
	logic                  cap_done;

	modport source (output cap_wr, cap_index, cap_data, cap_done);
	modport sink (input cap_wr, cap_index, cap_data, cap_done);

endinterface

`default_nettype wire

// ==== logic/ts_filter_regs.sv ====
`timescale 1ns/100ps
`include "ts_filter_settings.svh"
`default_nettype none

module ts_filter_regs
	import ts_filter_pkg::*;
(
	input  wire                    S_AXI_ACLK,
	input  wire                    S_AXI_ARESETN,
	input  wire [`TS_DATA_W/8-1:0] S_AXI_WSTRB,
	input  wire [`TS_DATA_W-1:0]   S_AXI_WDATA,
	input  wire                    mem_rden,
	input  wire                    mem_wren,
	input  wire [`TS_ADDR_W-1:0]   mem_address,
	filter_ctrl_if.regs            ctrl,
	input  wire [`TS_MON_NUM-1:0]  mon_ready,
	input  wire [`TS_REP_NUM-1:0]  rep_ready,
	output logic [`TS_IDX_W-1:0]   cap_rd_index,
	input  wire [`TS_DATA_W-1:0]   cap_rd_data,
	output logic [`TS_DATA_W-1:0]  axi_rdata
);

	localparam logic [`TS_ADDR_W-1:0] DATA_BASE = `TS_DATA_BASE;
	localparam logic [`TS_ADDR_W-1:0] DATA_END = `TS_DATA_BASE + `TS_PKT_WORDS;

	logic [`TS_ADDR_W-1:0]                  wr_addr;
	logic [`TS_DATA_W-1:0]                  wr_data;
	logic                                   wr_pend;
	logic [`TS_SLOT_W-1:0]                  cur_slot;
	logic [`TS_SLOT_NUM-1:0][`TS_PID_W-1:0] pid_table;
	logic [`TS_SLOT_NUM-1:0]                run_enable;
	logic [`TS_DATA_W-1:0]                  last_cmd;
	logic                                   rep_armed;
	logic                                   wr_in_window;
	logic                                   rd_in_window;
	logic [`TS_ADDR_W-1:0]                  wr_offset;
	logic [`TS_ADDR_W-1:0]                  rd_offset;
	logic [`TS_SLOT_NUM-1:0]                ready;

	assign ready = {rep_ready, mon_ready};
	assign wr_in_window = (wr_addr >= DATA_BASE) && (wr_addr < DATA_END);
	assign rd_in_window = (mem_address >= DATA_BASE) && (mem_address < DATA_END);
	assign wr_offset = wr_addr - DATA_BASE;
	assign rd_offset = mem_address - DATA_BASE;
	assign cap_rd_index = rd_offset[`TS_IDX_W-1:0];

	// first stage holds the strobe-merged data
	always_ff @(posedge S_AXI_ACLK) begin
		if (mem_wren) begin
			wr_addr <= mem_address;
			for (int b = 0; b < `TS_DATA_W/8; b++) begin
				if (S_AXI_WSTRB[b]) begin
					wr_data[8*b +: 8] <= S_AXI_WDATA[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= mem_wren;
		end
	end

	// second stage decode
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			cur_slot   <= '0;
			pid_table  <= '0;
			run_enable <= '0;
			last_cmd   <= CMD_NONE;
			rep_armed  <= 1'b0;
		end else if (wr_pend) begin
			// a load ends on the first write outside the window
			if (!wr_in_window) begin
				rep_armed <= 1'b0;
			end
			case (wr_addr)
				ADDR_INDEX: begin
					if (wr_data < `TS_SLOT_NUM) begin
						cur_slot <= wr_data[`TS_SLOT_W-1:0];
					end
				end
				ADDR_PID: pid_table[cur_slot] <= wr_data[`TS_PID_W-1:0];
				ADDR_RUN_ENABLE: run_enable[cur_slot] <= (wr_data == 1);
				ADDR_CMD: begin
					last_cmd <= wr_data;
					if (wr_data == CMD_WRITE_REPLACE_DATA && cur_slot >= `TS_MON_NUM) begin
						rep_armed <= 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		ctrl.read_req = '0;
		if (wr_pend && wr_addr == ADDR_CMD && wr_data == CMD_READ_REQUEST) begin
			ctrl.read_req[cur_slot] = 1'b1;
		end
	end

	assign ctrl.pid_table = pid_table;
	assign ctrl.run_enable = run_enable;
	assign ctrl.rep_wr = wr_pend && wr_in_window && rep_armed;
	assign ctrl.rep_slot = cur_slot;
	assign ctrl.rep_index = wr_offset[`TS_IDX_W-1:0];
	assign ctrl.rep_data = wr_data;

	always_ff @(posedge S_AXI_ACLK) begin
		if (mem_rden) begin
			case (mem_address)
				ADDR_INDEX:
					axi_rdata <= {{(`TS_DATA_W-`TS_SLOT_W){1'b0}}, cur_slot};
				ADDR_PID:
					axi_rdata <= {{(`TS_DATA_W-`TS_PID_W){1'b0}}, pid_table[cur_slot]};
				ADDR_RUN_ENABLE:
					axi_rdata <= {{(`TS_DATA_W-1){1'b0}}, run_enable[cur_slot]};
				ADDR_CMD:
					axi_rdata <= last_cmd;
				ADDR_STATUS:
					axi_rdata <= {{(`TS_DATA_W-1){1'b0}}, ready[cur_slot]};
				default: begin
					if (rd_in_window) begin
						axi_rdata <= cap_rd_data;
					end else begin
						axi_rdata <= `TS_UNMAPPED;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/pid_monitor_bank.sv ====
`timescale 1ns/100ps
`include "ts_filter_settings.svh"
`default_nettype none

module pid_monitor_bank
	import ts_filter_pkg::*;
(
	input  wire                    S_AXI_ACLK,
	input  wire                    S_AXI_ARESETN,
	input  wire [7:0]              mpeg_data,
	input  wire                    mpeg_valid,
	input  wire                    mpeg_sync,
	filter_ctrl_if.bank            ctrl,
	output logic [`TS_MON_NUM-1:0] ready,
	capture_if.source              cap
);

	localparam int LAST_BYTE = `TS_PKT_BYTES - 1;

	pkt_state_e             state;
	logic [7:0]             byte_cnt;
	logic [7:0]             byte_idx;
	logic                   byte_en;
	logic [4:0]             pid_hi;
	logic [`TS_PID_W-1:0]   pid;
	logic [23:0]            word_lo;
	logic [`TS_MON_NUM-1:0] match;
	logic [`TS_MON_NUM-1:0] armed;
	logic [`TS_MON_NUM-1:0] active;

	// sync always restarts at byte 0
	assign byte_idx = mpeg_sync ? 8'd0 : byte_cnt;
	assign byte_en = mpeg_valid && (mpeg_sync || state != PKT_IDLE);
	assign pid = {pid_hi, mpeg_data};

	always_comb begin
		for (int i = 0; i < `TS_MON_NUM; i++) begin
			match[i] = ctrl.run_enable[i] && (ctrl.pid_table[i] == pid);
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state    <= PKT_IDLE;
			byte_cnt <= '0;
		end else if (mpeg_valid) begin
			if (mpeg_sync) begin
				state    <= PKT_HEADER;
				byte_cnt <= 8'd1;
			end else if (state != PKT_IDLE) begin
				byte_cnt <= byte_cnt + 8'd1;
				if (byte_cnt == 8'd3) begin
					state <= PKT_BODY;
				end else if (byte_cnt == LAST_BYTE) begin
					state <= PKT_IDLE;
				end
			end
		end
	end

	// word packing with lane 0 in the low byte
	always_ff @(posedge S_AXI_ACLK) begin
		if (byte_en) begin
			if (byte_idx == 8'd1) begin
				pid_hi <= mpeg_data[4:0];
			end
			if (byte_idx[1:0] != 2'd3) begin
				word_lo[8*byte_idx[1:0] +: 8] <= mpeg_data;
			end else begin
				cap.cap_index <= byte_idx[7:2];
				cap.cap_data  <= {mpeg_data, word_lo};
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			armed        <= '0;
			active       <= '0;
			ready        <= '0;
			cap.cap_wr   <= 1'b0;
			cap.cap_done <= 1'b0;
		end else begin
			cap.cap_wr   <= byte_en && byte_idx[1:0] == 2'd3 && |active;
			cap.cap_done <= byte_en && byte_idx == LAST_BYTE && |active;
			// pid is complete at byte 2
			if (byte_en && byte_idx == 8'd2) begin
				active <= armed & match;
			end else if ((byte_en && mpeg_sync) || cap.cap_done) begin
				active <= '0;
			end
			for (int i = 0; i < `TS_MON_NUM; i++) begin
				if (ctrl.read_req[i]) begin
					armed[i] <= 1'b1;
					ready[i] <= 1'b0;
				end else begin
					if (|ctrl.read_req || (cap.cap_done && active[i])) begin
						armed[i] <= 1'b0;
					end
					if (cap.cap_done && active[i]) begin
						ready[i] <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/pid_replacer_bank.sv ====
`timescale 1ns/100ps
`include "ts_filter_settings.svh"
`default_nettype none

module pid_replacer_bank
	import ts_filter_pkg::*;
(
	input  wire                    S_AXI_ACLK,
	input  wire                    S_AXI_ARESETN,
	input  wire [7:0]              mpeg_data,
	input  wire                    mpeg_valid,
	input  wire                    mpeg_sync,
	filter_ctrl_if.bank            ctrl,
	output logic [`TS_REP_NUM-1:0] ready,
	capture_if.source              cap,
	output logic [7:0]             rep_data,
	output logic                   rep_valid,
	output logic                   rep_sync
);

	localparam int LAST_BYTE = `TS_PKT_BYTES - 1;
	localparam int SEL_W = $clog2(`TS_REP_NUM);
	localparam logic [`TS_SLOT_W-1:0] BASE = `TS_MON_NUM;

	pkt_state_e             state;
	logic [7:0]             byte_cnt;
	logic [7:0]             byte_idx;
	logic                   byte_en;
	logic [4:0]             pid_hi;
	logic [`TS_PID_W-1:0]   pid;
	logic [23:0]            word_lo;
	logic [`TS_REP_NUM-1:0] match;
	logic [`TS_REP_NUM-1:0] armed;
	logic [`TS_REP_NUM-1:0] active;
	logic [SEL_W-1:0]       first;
	logic [SEL_W-1:0]       sel;
	logic                   hit;
	logic [`TS_SLOT_W-1:0]  wr_slot;
	logic [`TS_DATA_W-1:0]  rep_word;
	logic [`TS_DATA_W-1:0]  rep_buf [`TS_REP_NUM][`TS_PKT_WORDS];

	assign byte_idx = mpeg_sync ? 8'd0 : byte_cnt;
	assign byte_en = mpeg_valid && (mpeg_sync || state != PKT_IDLE);
	assign pid = {pid_hi, mpeg_data};
	assign wr_slot = ctrl.rep_slot - BASE;
	assign rep_word = rep_buf[sel][byte_idx[7:2]];

	always_comb begin
		first = '0;
		for (int i = 0; i < `TS_REP_NUM; i++) begin
			match[i] = ctrl.run_enable[`TS_MON_NUM+i]
				&& (ctrl.pid_table[`TS_MON_NUM+i] == pid);
		end
		// lowest slot wins
		for (int i = `TS_REP_NUM - 1; i >= 0; i--) begin
			if (match[i]) begin
				first = SEL_W'(i);
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (ctrl.rep_wr) begin
			rep_buf[wr_slot[SEL_W-1:0]][ctrl.rep_index] <= ctrl.rep_data;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state    <= PKT_IDLE;
			byte_cnt <= '0;
			hit      <= 1'b0;
		end else if (mpeg_valid) begin
			if (mpeg_sync) begin
				state    <= PKT_HEADER;
				byte_cnt <= 8'd1;
				hit      <= 1'b0;
			end else if (state != PKT_IDLE) begin
				byte_cnt <= byte_cnt + 8'd1;
				if (byte_cnt == 8'd2) begin
					hit <= |match;
				end
				if (byte_cnt == 8'd3) begin
					state <= PKT_BODY;
				end else if (byte_cnt == LAST_BYTE) begin
					state <= PKT_IDLE;
				end
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (byte_en) begin
			if (byte_idx == 8'd1) begin
				pid_hi <= mpeg_data[4:0];
			end
			if (byte_idx == 8'd2) begin
				sel <= first;
			end
			if (byte_idx[1:0] != 2'd3) begin
				word_lo[8*byte_idx[1:0] +: 8] <= mpeg_data;
			end else begin
				cap.cap_index <= byte_idx[7:2];
				cap.cap_data  <= {mpeg_data, word_lo};
			end
		end
		// header bytes always pass through
		if (byte_en && hit && byte_idx >= 8'd4) begin
			rep_data <= rep_word[8*byte_idx[1:0] +: 8];
		end else begin
			rep_data <= mpeg_data;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			rep_valid    <= 1'b0;
			rep_sync     <= 1'b0;
			armed        <= '0;
			active       <= '0;
			ready        <= '0;
			cap.cap_wr   <= 1'b0;
			cap.cap_done <= 1'b0;
		end else begin
			rep_valid    <= mpeg_valid;
			rep_sync     <= mpeg_sync;
			cap.cap_wr   <= byte_en && byte_idx[1:0] == 2'd3 && |active;
			cap.cap_done <= byte_en && byte_idx == LAST_BYTE && |active;
			if (byte_en && byte_idx == 8'd2) begin
				active <= armed & match;
			end else if ((byte_en && mpeg_sync) || cap.cap_done) begin
				active <= '0;
			end
			for (int i = 0; i < `TS_REP_NUM; i++) begin
				if (ctrl.read_req[`TS_MON_NUM+i]) begin
					armed[i] <= 1'b1;
					ready[i] <= 1'b0;
				end else begin
					if (|ctrl.read_req || (cap.cap_done && active[i])) begin
						armed[i] <= 1'b0;
					end
					if (cap.cap_done && active[i]) begin
						ready[i] <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/ts_output_merge.sv ====
`timescale 1ns/100ps
`include "ts_filter_settings.svh"
`default_nettype none

module ts_output_merge (
	input  wire                   S_AXI_ACLK,
	input  wire                   S_AXI_ARESETN,
	capture_if.sink               mon_cap,
	capture_if.sink               rep_cap,
	input  wire [`TS_IDX_W-1:0]   cap_rd_index,
	output logic [`TS_DATA_W-1:0] cap_rd_data,
	input  wire [7:0]             rep_data,
	input  wire                   rep_valid,
	input  wire                   rep_sync,
	output logic [7:0]            ts_out,
	output logic                  ts_out_valid,
	output logic                  ts_out_sync
);

	logic [`TS_DATA_W-1:0] cap_ram [`TS_PKT_WORDS];

	// monitor bank first when both write
	always_ff @(posedge S_AXI_ACLK) begin
		if (mon_cap.cap_wr) begin
			cap_ram[mon_cap.cap_index] <= mon_cap.cap_data;
		end else if (rep_cap.cap_wr) begin
			cap_ram[rep_cap.cap_index] <= rep_cap.cap_data;
		end
	end

	assign cap_rd_data = cap_ram[cap_rd_index];

	// second stream register
	always_ff @(posedge S_AXI_ACLK) begin
		ts_out <= rep_data;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ts_out_valid <= 1'b0;
			ts_out_sync  <= 1'b0;
		end else begin
			ts_out_valid <= rep_valid;
			ts_out_sync  <= rep_sync;
		end
	end

endmodule

`default_nettype wire

// ==== logic/ts_filter_top.sv ====
`timescale 1ns/100ps
`include "ts_filter_settings.svh"
`default_nettype none

module ts_filter_top (
	input  wire                    S_AXI_ACLK,
	input  wire                    S_AXI_ARESETN,
	input  wire [`TS_DATA_W/8-1:0] S_AXI_WSTRB,
	input  wire [`TS_DATA_W-1:0]   S_AXI_WDATA,
	input  wire                    mem_rden,
	input  wire                    mem_wren,
	input  wire [`TS_ADDR_W-1:0]   mem_address,
	input  wire [7:0]              mpeg_data,
	input  wire                    mpeg_valid,
	input  wire                    mpeg_sync,
	output wire [`TS_DATA_W-1:0]   axi_rdata,
	output wire [7:0]              ts_out,
	output wire                    ts_out_valid,
	output wire                    ts_out_sync
);

	filter_ctrl_if ctrl ();
	capture_if mon_cap ();
	capture_if rep_cap ();

	logic [`TS_MON_NUM-1:0] mon_ready;
	logic [`TS_REP_NUM-1:0] rep_ready;
	logic [`TS_IDX_W-1:0]   cap_rd_index;
	logic [`TS_DATA_W-1:0]  cap_rd_data;
	logic [7:0]             rep_data;
	logic                   rep_valid;
	logic                   rep_sync;

	ts_filter_regs ts_filter_regs_inst (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.mem_rden      (mem_rden),
		.mem_wren      (mem_wren),
		.mem_address   (mem_address),
		.ctrl          (ctrl.regs),
		.mon_ready     (mon_ready),
		.rep_ready     (rep_ready),
		.cap_rd_index  (cap_rd_index),
		.cap_rd_data   (cap_rd_data),
		.axi_rdata     (axi_rdata)
	);

	pid_monitor_bank pid_monitor_bank_inst (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.mpeg_data     (mpeg_data),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.ctrl          (ctrl.bank),
		.ready         (mon_ready),
		.cap           (mon_cap.source)
	);

	pid_replacer_bank pid_replacer_bank_inst (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.mpeg_data     (mpeg_data),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.ctrl          (ctrl.bank),
		.ready         (rep_ready),
		.cap           (rep_cap.source),
		.rep_data      (rep_data),
		.rep_valid     (rep_valid),
		.rep_sync      (rep_sync)
	);

	ts_output_merge ts_output_merge_inst (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.mon_cap       (mon_cap.sink),
		.rep_cap       (rep_cap.sink),
		.cap_rd_index  (cap_rd_index),
		.cap_rd_data   (cap_rd_data),
		.rep_data      (rep_data),
		.rep_valid     (rep_valid),
		.rep_sync      (rep_sync),
		.ts_out        (ts_out),
		.ts_out_valid  (ts_out_valid),
		.ts_out_sync   (ts_out_sync)
	);

endmodule

`default_nettype wire

// ==== testbench/ts_filter_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module ts_filter_asserts (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire mpeg_valid,
	input wire ts_out_valid,
	input wire mon_cap_wr,
	input wire rep_cap_wr
);

	// failed assertions so far
	int fails = 0;

	// two register stages between input and output
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		ts_out_valid == $past(mpeg_valid, 2))
	else begin
		fails++;
		$error("ts_out_valid does not follow mpeg_valid by two cycles");
	end

	assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=> !ts_out_valid)
	else begin
		fails++;
		$error("ts_out_valid high during reset");
	end

	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(mon_cap_wr && rep_cap_wr))
	else begin
		fails++;
		$error("both banks write the capture RAM in the same cycle");
	end

endmodule

bind ts_filter_top ts_filter_asserts ts_filter_asserts_inst (
	.S_AXI_ACLK    (S_AXI_ACLK),
	.S_AXI_ARESETN (S_AXI_ARESETN),
	.mpeg_valid    (mpeg_valid),
	.ts_out_valid  (ts_out_valid),
	.mon_cap_wr    (mon_cap.cap_wr),
	.rep_cap_wr    (rep_cap.cap_wr)
);

`default_nettype wire

// ==== testbench/ts_filter_tb.sv ====
`timescale 1ns/100ps
`include "ts_filter_settings.svh"
`default_nettype none

module ts_filter_tb;

	localparam int MAX_LINES = 128;
	localparam int TABLE_SIZE = 8;

	logic                    S_AXI_ACLK;
	logic                    S_AXI_ARESETN;
	logic [`TS_DATA_W/8-1:0] S_AXI_WSTRB;
	logic [`TS_DATA_W-1:0]   S_AXI_WDATA;
	logic                    mem_rden;
	logic                    mem_wren;
	logic [`TS_ADDR_W-1:0]   mem_address;
	logic [7:0]              mpeg_data;
	logic                    mpeg_valid;
	logic                    mpeg_sync;
	wire  [`TS_DATA_W-1:0]   axi_rdata;
	wire  [7:0]              ts_out;
	wire                     ts_out_valid;
	wire                     ts_out_sync;

	// record is {op, a, b}
	logic [71:0]          script [MAX_LINES];
	// mirror of the register state
	logic [1:0]           cur_slot;
	logic [`TS_PID_W-1:0] pid_mirror [`TS_SLOT_NUM];
	logic [3:0]           en_mirror;
	logic                 rep_armed;
	logic [7:0]           rep_model [`TS_REP_NUM][`TS_PKT_BYTES];
	// last packet sent for each pid
	logic [`TS_PID_W-1:0] sent_pid [TABLE_SIZE];
	logic [7:0]           sent_pkt [TABLE_SIZE][`TS_PKT_BYTES];
	int                   sent_used;
	logic [31:0]          lfsr;
	// {valid, sync, data} at the input and two cycles later
	logic [9:0]           exp_now;
	logic [9:0]           exp_d1;
	logic [9:0]           exp_d2;
	logic                 checking;
	int                   errors;
	int                   test_errors;
	int                   tests_run;
	int                   tests_failed;
	int                   cycles;
	int                   cycle_limit;

	ts_filter_top ts_filter_top_inst (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.mem_rden      (mem_rden),
		.mem_wren      (mem_wren),
		.mem_address   (mem_address),
		.mpeg_data     (mpeg_data),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.axi_rdata     (axi_rdata),
		.ts_out        (ts_out),
		.ts_out_valid  (ts_out_valid),
		.ts_out_sync   (ts_out_sync)
	);

	always #5 S_AXI_ACLK = ~S_AXI_ACLK;

	always @(posedge S_AXI_ACLK) begin
		exp_d2 <= exp_d1;
		exp_d1 <= exp_now;
	end

	// outputs only move on the rising edge
	always @(negedge S_AXI_ACLK) begin
		if (checking) begin
			check_value("ts_out_valid", exp_d2[9], ts_out_valid);
			check_value("ts_out_sync", exp_d2[8], ts_out_sync);
			if (exp_d2[9]) begin
				check_value("ts_out", exp_d2[7:0], ts_out);
			end
		end
	end

	always @(posedge S_AXI_ACLK) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the script did not finish", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
	endtask

	function automatic int lookup_pid(input logic [`TS_PID_W-1:0] pid);
		for (int i = 0; i < sent_used; i++) begin
			if (sent_pid[i] == pid) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
		int idx;
		if (addr >= `TS_DATA_BASE && addr < `TS_DATA_BASE + `TS_PKT_WORDS) begin
			if (rep_armed) begin
				idx = addr - `TS_DATA_BASE;
				for (int b = 0; b < 4; b++) begin
					rep_model[cur_slot - `TS_MON_NUM][4*idx + b] = data[8*b +: 8];
				end
			end
		end else begin
			rep_armed = 1'b0;
			case (addr)
				8'd0: if (data < `TS_SLOT_NUM) cur_slot = data[1:0];
				8'd1: pid_mirror[cur_slot] = data[`TS_PID_W-1:0];
				8'd2: en_mirror[cur_slot] = (data == 1);
				8'd3: if (data == 1 && cur_slot >= `TS_MON_NUM) rep_armed = 1'b1;
				default: ;
			endcase
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		mem_wren = 1'b1;
		mem_address = addr;
		S_AXI_WDATA = data;
		@(negedge S_AXI_ACLK);
		mem_wren = 1'b0;
		model_write(addr, data);
		// decode lands one edge later
		@(negedge S_AXI_ACLK);
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
		mem_rden = 1'b1;
		mem_address = addr;
		@(negedge S_AXI_ACLK);
		mem_rden = 1'b0;
		check_value($sformatf("axi_rdata @%h", addr), expected, axi_rdata);
	endtask

	task automatic fill_window(input logic [31:0] seed);
		for (int i = 0; i < `TS_PKT_WORDS; i++) begin
			write_reg(`TS_DATA_BASE + i, seed + i * 32'h01030507);
		end
	endtask

	task automatic send_packet(input logic [`TS_PID_W-1:0] pid);
		logic [7:0] pkt [`TS_PKT_BYTES];
		logic [7:0] gap;
		logic [7:0] exp_byte;
		int         entry;
		int         hit_slot;
		hit_slot = -1;
		for (int s = `TS_SLOT_NUM - 1; s >= `TS_MON_NUM; s--) begin
			if (en_mirror[s] && pid_mirror[s] == pid) begin
				hit_slot = s;
			end
		end
		for (int k = 0; k < `TS_PKT_BYTES; k++) begin
			take_bits(8, pkt[k]);
		end
		pkt[0] = 8'h47;
		pkt[1] = {3'b010, pid[12:8]};
		pkt[2] = pid[7:0];
		entry = lookup_pid(pid);
		if (entry < 0) begin
			entry = sent_used % TABLE_SIZE;
			sent_pid[entry] = pid;
			if (sent_used < TABLE_SIZE) begin
				sent_used++;
			end
		end
		for (int k = 0; k < `TS_PKT_BYTES; k++) begin
			sent_pkt[entry][k] = pkt[k];
		end
		for (int k = 0; k < `TS_PKT_BYTES; k++) begin
			take_bits(2, gap);
			if (gap == 0) begin
				mpeg_valid = 1'b0;
				mpeg_sync = 1'b0;
				exp_now = '0;
				@(negedge S_AXI_ACLK);
			end
			// header bytes are never replaced
			exp_byte = (hit_slot >= 0 && k >= 4) ? rep_model[hit_slot - `TS_MON_NUM][k] : pkt[k];
			mpeg_valid = 1'b1;
			mpeg_sync = (k == 0);
			mpeg_data = pkt[k];
			exp_now = {1'b1, k == 0, exp_byte};
			@(negedge S_AXI_ACLK);
		end
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		exp_now = '0;
	endtask

	task automatic check_capture(input logic [`TS_PID_W-1:0] pid);
		int          entry;
		logic [31:0] word;
		entry = lookup_pid(pid);
		if (entry < 0) begin
			$display("capture check for pid %h, but no packet with that pid was sent", pid);
			errors++;
			test_errors++;
		end else begin
			for (int w = 0; w < `TS_PKT_WORDS; w++) begin
				word = {sent_pkt[entry][4*w + 3], sent_pkt[entry][4*w + 2],
					sent_pkt[entry][4*w + 1], sent_pkt[entry][4*w]};
				read_check(`TS_DATA_BASE + w, word);
			end
		end
	endtask

	initial begin
		logic [7:0]  op;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		int          n_lines;
		int          n_pkts;
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		S_AXI_WSTRB = '1;
		S_AXI_WDATA = '0;
		mem_rden = 1'b0;
		mem_wren = 1'b0;
		mem_address = '0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		exp_now = '0;
		checking = 1'b0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		cycle_limit = 0;
		lfsr = 32'd74247;
		cur_slot = '0;
		en_mirror = '0;
		rep_armed = 1'b0;
		sent_used = 0;
		for (int s = 0; s < `TS_SLOT_NUM; s++) begin
			pid_mirror[s] = '0;
		end
		for (int s = 0; s < `TS_REP_NUM; s++) begin
			for (int k = 0; k < `TS_PKT_BYTES; k++) begin
				rep_model[s][k] = '0;
			end
		end
		for (int i = 0; i < MAX_LINES; i++) begin
			script[i] = '0;
		end
		$readmemh("testbench/ts_filter_golden.txt", script);
		n_lines = 0;
		n_pkts = 0;
		while (n_lines < MAX_LINES && script[n_lines][71:64] != 8'h00) begin
			if (script[n_lines][71:64] == "P") begin
				n_pkts += script[n_lines][31:0];
			end
			n_lines++;
		end
		if (n_lines == 0) begin
			$display("no commands read from the golden file");
			errors++;
		end
		// worst case one idle cycle per byte
		cycle_limit = 100 + n_pkts * 400 + n_lines * 150;
		repeat (3) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		@(negedge S_AXI_ACLK);
		checking = 1'b1;
		for (int i = 0; i < n_lines; i++) begin
			op = script[i][71:64];
			arg_a = script[i][63:32];
			arg_b = script[i][31:0];
			case (op)
				"W": write_reg(arg_a[7:0], arg_b);
				"R": read_check(arg_a[7:0], arg_b);
				"D": fill_window(arg_b);
				"P": begin
					repeat (arg_b) send_packet(arg_a[`TS_PID_W-1:0]);
					// let the output pipe and ready bits settle
					repeat (4) @(negedge S_AXI_ACLK);
				end
				"C": check_capture(arg_a[`TS_PID_W-1:0]);
				"T": begin
					tests_run++;
					if (test_errors == 0) begin
						$display("test %0d passed", arg_a);
					end else begin
						tests_failed++;
						$display("test %0d failed with %0d errors", arg_a, test_errors);
					end
					test_errors = 0;
				end
				default: begin
					$display("unknown command %h on script line %0d", op, i);
					errors++;
					test_errors++;
				end
			endcase
		end
		repeat (4) @(negedge S_AXI_ACLK);
		errors += ts_filter_top_inst.ts_filter_asserts_inst.fails;
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/ts_filter_pkg.sv
logic/filter_ctrl_if.sv
logic/capture_if.sv
logic/ts_filter_regs.sv
logic/pid_monitor_bank.sv
logic/pid_replacer_bank.sv
logic/ts_output_merge.sv
logic/ts_filter_top.sv
testbench/ts_filter_asserts.sv
testbench/ts_filter_tb.sv

// ==== testbench/ts_filter_golden.txt ====
// columns: op_a_b, op is the ASCII command letter: 57 W write b to a, 52 R read a expect b,
// 44 D load data window with seed b, 50 P send b packets of pid a,
// 43 C check capture window against pid a, 54 T end of test number a
// test 1, register readback
57_00000000_00000001
57_00000001_00000123
57_00000002_00000005
52_00000000_00000001
52_00000001_00000123
52_00000002_00000000
57_00000000_00000007
52_00000000_00000001
57_00000003_00000002
52_00000003_00000002
52_00000040_FF00FF00
52_000000F0_FF00FF00
54_00000001_00000000
// test 2, monitor capture on slot 0
57_00000000_00000000
57_00000001_00000100
57_00000002_00000001
57_00000003_00000002
50_00000055_00000002
50_00000100_00000001
52_00000004_00000001
43_00000100_00000000
54_00000002_00000000
// test 3, replacement on slot 2
57_00000000_00000002
57_00000001_00000200
57_00000003_00000001
44_00000000_A5C31E00
57_00000002_00000001
50_00000200_00000002
50_00000055_00000001
50_00000200_00000001
54_00000003_00000000
// test 4, disabled slots
57_00000000_00000003
57_00000001_00000300
57_00000002_00000000
57_00000003_00000002
50_00000300_00000001
52_00000004_00000000
57_00000000_00000002
57_00000002_00000000
50_00000200_00000001
54_00000004_00000000
// test 5, replacer capture on slot 3, then a load attempt on monitor slot 1
57_00000000_00000003
57_00000003_00000001
44_00000000_3C5A9600
57_00000002_00000001
57_00000003_00000002
50_00000300_00000001
52_00000004_00000001
43_00000300_00000000
57_00000000_00000001
57_00000003_00000001
44_00000000_0F0F0F0F
50_00000300_00000001
54_00000005_00000000
